/* rtl/vga_pkg.sv */
// ####################
// xga raster constants, counter width
// colour word union and named colours
// ####################

package vga_pkg;

  // horizontal raster, in pixels
  localparam int H_ACTIVE = 1024;
  localparam int H_FRONT  = 24;
  localparam int H_SYNC   = 136;
  localparam int H_BACK   = 160;
  // 1344 pixels per line
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // vertical raster, in lines
  localparam int V_ACTIVE = 768;
  localparam int V_FRONT  = 3;
  localparam int V_SYNC   = 6;
  localparam int V_BACK   = 29;
  // 806 lines per frame
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // both counters share one width
  localparam int COUNT_W  = 12;

  // 12-bit colour word
  // word view for muxing and pipeline regs
  // chan view only at the pins, chan[2] red, chan[1] green, chan[0] blue
  typedef union packed {
    logic [11:0]      word;
    logic [2:0][3:0]  chan;
  } rgb_t;

  // border and fill colours
  localparam rgb_t COLOR_BLACK  = 12'h000;
  localparam rgb_t COLOR_YELLOW = 12'hff0;
  localparam rgb_t COLOR_RED    = 12'hf00;
  localparam rgb_t COLOR_GREEN  = 12'h0f0;
  localparam rgb_t COLOR_BLUE   = 12'h00f;
  localparam rgb_t COLOR_GRAY   = 12'h888;

  // rectangle fills, b while the button is held
  localparam rgb_t COLOR_RECT_A = 12'h44f;
  localparam rgb_t COLOR_RECT_B = 12'hf80;

endpackage

/* rtl/vga_timing.sv */
// ####################
// raster counters for xga 1024x768
// registered sync and blanking flags
// ####################

`timescale 1ns/1ps

module vga_timing import vga_pkg::*; (
  input  logic               pclk,
  input  logic               reset,
  output logic [COUNT_W-1:0] hcount,
  output logic [COUNT_W-1:0] vcount,
  output logic               hsync,
  output logic               vsync,
  output logic               hblnk,
  output logic               vblnk
);

  // window edges, start inclusive, end exclusive
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int HS_END   = HS_START + H_SYNC;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;

  logic               h_last;
  logic               v_last;
  logic [COUNT_W-1:0] h_next;
  logic [COUNT_W-1:0] v_next;

  // end of line and end of frame
  assign h_last = (hcount == COUNT_W'(H_TOTAL - 1));
  assign v_last = (vcount == COUNT_W'(V_TOTAL - 1));

  // next counts, vertical steps only on line wrap
  always_comb begin
    h_next = h_last ? '0 : hcount + 1'b1;
    v_next = vcount;
    if (h_last) begin
      v_next = v_last ? '0 : vcount + 1'b1;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= h_next;
      vcount <= v_next;
      // flags decoded from next counts
      // so they line up with the registered counters
      hblnk  <= (h_next >= H_ACTIVE);
      hsync  <= (h_next >= HS_START) && (h_next < HS_END);
      vblnk  <= (v_next >= V_ACTIVE);
      vsync  <= (v_next >= VS_START) && (v_next < VS_END);
    end
  end

  // counters never leave the raster
  a_count_range : assert property (
    @(posedge pclk) disable iff (reset)
    (hcount < H_TOTAL) && (vcount < V_TOTAL)
  ) else $error("vga_timing count out of range h=%0d v=%0d", hcount, vcount);

endmodule

/* rtl/frame_ctl.sv */
// ####################
// per-frame pointer sampling
// clamp to screen, hold for one frame
// ####################

`timescale 1ns/1ps

module frame_ctl import vga_pkg::*; #(
  parameter int RECT_W = 64,
  parameter int RECT_H = 48
) (
  input  logic               pclk,
  input  logic               reset,
  input  logic [COUNT_W-1:0] hcount,
  input  logic [COUNT_W-1:0] vcount,
  input  logic [COUNT_W-1:0] xpos,
  input  logic [COUNT_W-1:0] ypos,
  input  logic               mouse_left,
  output logic [COUNT_W-1:0] rect_x,
  output logic [COUNT_W-1:0] rect_y,
  output logic               rect_alt
);

  // largest top-left corner that keeps the rectangle on screen
  localparam logic [COUNT_W-1:0] X_MAX = COUNT_W'(H_ACTIVE - RECT_W);
  localparam logic [COUNT_W-1:0] Y_MAX = COUNT_W'(V_ACTIVE - RECT_H);

  logic               frame_end;
  logic [COUNT_W-1:0] x_clamp;
  logic [COUNT_W-1:0] y_clamp;

  // last raster cycle of the frame
  assign frame_end = (hcount == COUNT_W'(H_TOTAL - 1)) &&
                     (vcount == COUNT_W'(V_TOTAL - 1));

  // pin to right and bottom edge
  assign x_clamp = (xpos > X_MAX) ? X_MAX : xpos;
  assign y_clamp = (ypos > Y_MAX) ? Y_MAX : ypos;

  // new values show from the first pixel of the next frame
  always_ff @(posedge pclk) begin
    if (reset) begin
      rect_x   <= '0;
      rect_y   <= '0;
      rect_alt <= 1'b0;
    end else if (frame_end) begin
      rect_x   <= x_clamp;
      rect_y   <= y_clamp;
      rect_alt <= mouse_left;
    end
  end

  // no tearing, outputs move only right after the frame-end sample
  a_frame_hold : assert property (
    @(posedge pclk) disable iff (reset)
    !$stable({rect_x, rect_y, rect_alt}) |-> $past(frame_end)
  ) else $error("frame_ctl outputs changed mid-frame");

endmodule

/* rtl/draw_background.sv */
// ####################
// pipeline stage 1
// border lines, gray fill, black blanking
// ####################

`timescale 1ns/1ps

module draw_background import vga_pkg::*; (
  input  logic               pclk,
  input  logic               reset,
  input  logic [COUNT_W-1:0] hcount,
  input  logic [COUNT_W-1:0] vcount,
  input  logic               hsync,
  input  logic               vsync,
  input  logic               hblnk,
  input  logic               vblnk,
  output logic [COUNT_W-1:0] hcount_d,
  output logic [COUNT_W-1:0] vcount_d,
  output logic               hsync_d,
  output logic               vsync_d,
  output logic               blank_d,
  output rgb_t               rgb_bg
);

  // edge rows and columns of the visible area
  localparam logic [COUNT_W-1:0] ROW_TOP    = '0;
  localparam logic [COUNT_W-1:0] ROW_BOTTOM = COUNT_W'(V_ACTIVE - 1);
  localparam logic [COUNT_W-1:0] COL_LEFT   = '0;
  localparam logic [COUNT_W-1:0] COL_RIGHT  = COUNT_W'(H_ACTIVE - 1);

  logic blank;
  rgb_t rgb_next;

  // either blanking interval hides the pixel
  assign blank = hblnk || vblnk;

  // priority select, first match wins
  always_comb begin
    if (blank) begin
      // nothing visible
      rgb_next = COLOR_BLACK;
    end else if (vcount == ROW_TOP) begin
      // top line
      rgb_next = COLOR_YELLOW;
    end else if (vcount == ROW_BOTTOM) begin
      // bottom line
      rgb_next = COLOR_RED;
    end else if (hcount == COL_LEFT) begin
      // left column
      rgb_next = COLOR_GREEN;
    end else if (hcount == COL_RIGHT) begin
      // right column
      rgb_next = COLOR_BLUE;
    end else begin
      // interior
      rgb_next = COLOR_GRAY;
    end
  end

  // one register stage for colour, counters and syncs
  always_ff @(posedge pclk) begin
    if (reset) begin
      hcount_d <= '0;
      vcount_d <= '0;
      hsync_d  <= 1'b0;
      vsync_d  <= 1'b0;
      // held blanked so stage 2 stays dark
      blank_d  <= 1'b1;
      rgb_bg   <= COLOR_BLACK;
    end else begin
      hcount_d <= hcount;
      vcount_d <= vcount;
      hsync_d  <= hsync;
      vsync_d  <= vsync;
      blank_d  <= blank;
      rgb_bg   <= rgb_next;
    end
  end

endmodule

/* rtl/draw_rect.sv */
// ####################
// pipeline stage 2
// rectangle overlay, registered vga pins
// ####################

`timescale 1ns/1ps

module draw_rect import vga_pkg::*; #(
  parameter int RECT_W = 64,
  parameter int RECT_H = 48
) (
  input  logic               pclk,
  input  logic               reset,
  input  logic [COUNT_W-1:0] hcount_d,
  input  logic [COUNT_W-1:0] vcount_d,
  input  logic               hsync_d,
  input  logic               vsync_d,
  input  logic               blank_d,
  input  rgb_t               rgb_bg,
  input  logic [COUNT_W-1:0] rect_x,
  input  logic [COUNT_W-1:0] rect_y,
  input  logic               rect_alt,
  output logic               hs,
  output logic               vs,
  output logic [3:0]         r,
  output logic [3:0]         g,
  output logic [3:0]         b
);

  // one past the last column and row of the rectangle
  logic [COUNT_W-1:0] x_end;
  logic [COUNT_W-1:0] y_end;
  logic               in_rect;
  rgb_t               rgb_next;
  rgb_t               rgb_q;

  // clamped corner keeps these within 12 bits
  assign x_end = rect_x + COUNT_W'(RECT_W);
  assign y_end = rect_y + COUNT_W'(RECT_H);

  // hit test, never during blanking
  assign in_rect = !blank_d &&
                   (hcount_d >= rect_x) && (hcount_d < x_end) &&
                   (vcount_d >= rect_y) && (vcount_d < y_end);

  // button level picks the fill
  always_comb begin
    rgb_next = rgb_bg;
    if (in_rect) begin
      rgb_next = rect_alt ? COLOR_RECT_B : COLOR_RECT_A;
    end
  end

  // output register, drives the pins
  always_ff @(posedge pclk) begin
    if (reset) begin
      hs    <= 1'b0;
      vs    <= 1'b0;
      rgb_q <= COLOR_BLACK;
    end else begin
      hs    <= hsync_d;
      vs    <= vsync_d;
      rgb_q <= rgb_next;
    end
  end

  // split through the channel view
  assign r = rgb_q.chan[2];
  assign g = rgb_q.chan[1];
  assign b = rgb_q.chan[0];

  // blanked pixel from stage 1 must reach the pins black
  a_black_in_blank : assert property (
    @(posedge pclk) disable iff (reset)
    $past(blank_d) |-> (rgb_q.word == COLOR_BLACK.word)
  ) else $error("draw_rect colour %h during blanking", rgb_q.word);

endmodule

/* rtl/vga_top.sv */
// ####################
// xga pixel pipeline top
// timing, frame control, two draw stages
// ####################

`timescale 1ns/1ps

module vga_top import vga_pkg::*; #(
  parameter int RECT_W = 64,
  parameter int RECT_H = 48
) (
  input  logic               pclk,
  input  logic               reset,
  input  logic [COUNT_W-1:0] xpos,
  input  logic [COUNT_W-1:0] ypos,
  input  logic               mouse_left,
  output logic               hs,
  output logic               vs,
  output logic [3:0]         r,
  output logic [3:0]         g,
  output logic [3:0]         b
);

  // raster from the timing generator
  logic [COUNT_W-1:0] hcount;
  logic [COUNT_W-1:0] vcount;
  logic               hsync;
  logic               vsync;
  logic               hblnk;
  logic               vblnk;

  // stage 1 outputs
  logic [COUNT_W-1:0] hcount_d;
  logic [COUNT_W-1:0] vcount_d;
  logic               hsync_d;
  logic               vsync_d;
  logic               blank_d;
  rgb_t               rgb_bg;

  // per-frame rectangle state
  logic [COUNT_W-1:0] rect_x;
  logic [COUNT_W-1:0] rect_y;
  logic               rect_alt;

  vga_timing timing_i (
    .pclk   (pclk),
    .reset  (reset),
    .hcount (hcount),
    .vcount (vcount),
    .hsync  (hsync),
    .vsync  (vsync),
    .hblnk  (hblnk),
    .vblnk  (vblnk)
  );

  // pointer sampled once per frame
  frame_ctl #(
    .RECT_W (RECT_W),
    .RECT_H (RECT_H)
  ) frame_ctl_i (
    .pclk       (pclk),
    .reset      (reset),
    .hcount     (hcount),
    .vcount     (vcount),
    .xpos       (xpos),
    .ypos       (ypos),
    .mouse_left (mouse_left),
    .rect_x     (rect_x),
    .rect_y     (rect_y),
    .rect_alt   (rect_alt)
  );

  draw_background background_i (
    .pclk     (pclk),
    .reset    (reset),
    .hcount   (hcount),
    .vcount   (vcount),
    .hsync    (hsync),
    .vsync    (vsync),
    .hblnk    (hblnk),
    .vblnk    (vblnk),
    .hcount_d (hcount_d),
    .vcount_d (vcount_d),
    .hsync_d  (hsync_d),
    .vsync_d  (vsync_d),
    .blank_d  (blank_d),
    .rgb_bg   (rgb_bg)
  );

  // overlay and pin register
  draw_rect #(
    .RECT_W (RECT_W),
    .RECT_H (RECT_H)
  ) rect_i (
    .pclk     (pclk),
    .reset    (reset),
    .hcount_d (hcount_d),
    .vcount_d (vcount_d),
    .hsync_d  (hsync_d),
    .vsync_d  (vsync_d),
    .blank_d  (blank_d),
    .rgb_bg   (rgb_bg),
    .rect_x   (rect_x),
    .rect_y   (rect_y),
    .rect_alt (rect_alt),
    .hs       (hs),
    .vs       (vs),
    .r        (r),
    .g        (g),
    .b        (b)
  );

endmodule

/* tests/tb_checks.svh */
// ####################
// concurrent checks on the vga pins
// against the delayed reference predictions
// ####################

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // dark in reset and the two cycles after release
  a_reset_rgb : assert property (
    @(posedge pclk)
    armed && (reset || $past(reset) || $past(reset, 2)) |-> ({r, g, b} == 12'h000)
  ) else report_mismatch("rgb", 12'h000, $sampled({r, g, b}));

  a_reset_sync : assert property (
    @(posedge pclk)
    armed && (reset || $past(reset) || $past(reset, 2)) |-> (!hs && !vs)
  ) else report_mismatch("hs_vs", 12'h000, {10'h0, $sampled(hs), $sampled(vs)});

  // sync windows, every cycle of the run
  a_hsync : assert property (
    @(posedge pclk)
    armed |-> (hs == exp_hs_q)
  ) else report_mismatch("hs", {11'h0, $sampled(exp_hs_q)}, {11'h0, $sampled(hs)});

  a_vsync : assert property (
    @(posedge pclk)
    armed |-> (vs == exp_vs_q)
  ) else report_mismatch("vs", {11'h0, $sampled(exp_vs_q)}, {11'h0, $sampled(vs)});

  // black outside the visible area
  a_blank_black : assert property (
    @(posedge pclk)
    armed && exp_blank_q |-> ({r, g, b} == 12'h000)
  ) else report_mismatch("rgb", 12'h000, $sampled({r, g, b}));

  // border lines and gray fill
  a_background : assert property (
    @(posedge pclk)
    armed && !exp_blank_q && !exp_in_rect_q |-> ({r, g, b} == exp_rgb_q)
  ) else report_mismatch("rgb", $sampled(exp_rgb_q), $sampled({r, g, b}));

  // rectangle at the position sampled last frame end
  // mid-frame moves would show up here as a wrong edge
  a_rect_fill : assert property (
    @(posedge pclk)
    armed && exp_in_rect_q |-> ({r, g, b} == exp_rgb_q)
  ) else report_mismatch("rgb", $sampled(exp_rgb_q), $sampled({r, g, b}));

  // channel split, red on top
  a_red_channel : assert property (
    @(posedge pclk)
    armed |-> (r == exp_rgb_q[11:8])
  ) else report_mismatch("r", {8'h0, $sampled(exp_rgb_q[11:8])}, {8'h0, $sampled(r)});

  a_blue_channel : assert property (
    @(posedge pclk)
    armed |-> (b == exp_rgb_q[3:0])
  ) else report_mismatch("b", {8'h0, $sampled(exp_rgb_q[3:0])}, {8'h0, $sampled(b)});

`endif

/* tests/tb_vga_top.sv */
// ####################
// testbench for the xga pixel pipeline
// clock, reset, pointer stimulus
// reference raster, rectangle and timeout
// ####################

`timescale 1ns/1ps

module tb_vga_top;

  // raster rules, as the display expects them
  localparam logic [11:0] H_VISIBLE  = 12'd1024;
  localparam logic [11:0] V_VISIBLE  = 12'd768;
  localparam logic [11:0] LINE_LAST  = 12'd1343;
  localparam logic [11:0] FRAME_LAST = 12'd805;
  localparam logic [11:0] HS_FIRST   = 12'd1048;
  localparam logic [11:0] HS_LAST    = 12'd1183;
  localparam logic [11:0] VS_FIRST   = 12'd771;
  localparam logic [11:0] VS_LAST    = 12'd776;
  // rectangle size and the largest on-screen corner
  localparam logic [11:0] BOX_W      = 12'd64;
  localparam logic [11:0] BOX_H      = 12'd48;
  localparam logic [11:0] X_LIMIT    = 12'd960;
  localparam logic [11:0] Y_LIMIT    = 12'd720;

  localparam int SEED           = 35;
  localparam int RESET_CYCLES   = 16;
  localparam int LINE_CYCLES    = 1344;
  localparam int FRAME_CYCLES   = 1344 * 806;
  localparam int RUN_FRAMES     = 3;
  // one frame of slack past the three-frame run
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * FRAME_CYCLES;

  // mid-frame pointer moves, then the value for the frame-end sample
  localparam logic [11:0] MOVE_LINES [4] = '{12'd100, 12'd300, 12'd500, 12'd700};
  localparam logic [11:0] SETUP_LINE = 12'd790;

  logic        pclk = 1'b0;
  logic        reset;
  logic [11:0] xpos;
  logic [11:0] ypos;
  logic        mouse_left;
  logic        hs;
  logic        vs;
  logic [3:0]  r;
  logic [3:0]  g;
  logic [3:0]  b;

  // reference raster and rectangle
  logic [11:0] ref_hc;
  logic [11:0] ref_vc;
  logic [11:0] ref_rx;
  logic [11:0] ref_ry;
  logic        ref_alt;
  logic        ref_frame_end;

  // predictions for the current counts
  logic        exp_hs_now;
  logic        exp_vs_now;
  logic        exp_blank_now;
  logic        exp_in_rect_now;
  logic [11:0] exp_rgb_now;

  // same predictions, two cycles later
  logic        exp_hs_d1 = 1'b0;
  logic        exp_vs_d1 = 1'b0;
  logic        exp_blank_d1 = 1'b0;
  logic        exp_in_rect_d1 = 1'b0;
  logic [11:0] exp_rgb_d1 = '0;
  logic        exp_hs_q = 1'b0;
  logic        exp_vs_q = 1'b0;
  logic        exp_blank_q = 1'b0;
  logic        exp_in_rect_q = 1'b0;
  logic [11:0] exp_rgb_q = '0;

  int   cycle_cnt = 0;
  logic armed;
  // stimulus reach counters
  int   fill_a_pixels = 0;
  int   fill_b_pixels = 0;
  int   clamp_x_samples = 0;
  int   clamp_y_samples = 0;

  vga_top dut_i (
    .pclk       (pclk),
    .reset      (reset),
    .xpos       (xpos),
    .ypos       (ypos),
    .mouse_left (mouse_left),
    .hs         (hs),
    .vs         (vs),
    .r          (r),
    .g          (g),
    .b          (b)
  );

  // 250 MHz sim clock, only the cycle count matters
  always #2 pclk = ~pclk;

  task automatic end_with_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    end_with_failure();
  endtask

  task automatic report_mismatch(input string sig, input logic [11:0] expected,
                                 input logic [11:0] actual);
    $display("ERR %s expected %h got %h at %0t", sig, expected, actual, $time);
    end_with_failure();
  endtask

  function automatic logic [11:0] clamp_to_limit(input logic [11:0] value,
                                                 input logic [11:0] limit);
    return (value > limit) ? limit : value;
  endfunction

  // border priority: top, bottom, left, right, then fill
  function automatic logic [11:0] border_colour(input logic [11:0] h, input logic [11:0] v);
    if (v == 12'd0) return 12'hff0;
    if (v == V_VISIBLE - 12'd1) return 12'hf00;
    if (h == 12'd0) return 12'h0f0;
    if (h == H_VISIBLE - 12'd1) return 12'h00f;
    return 12'h888;
  endfunction

  assign armed = (cycle_cnt >= 3);
  assign ref_frame_end = (ref_hc == LINE_LAST) && (ref_vc == FRAME_LAST);

  // reference counters, (0,0) in the first cycle after reset
  always @(posedge pclk) begin
    if (reset) begin
      ref_hc <= '0;
      ref_vc <= '0;
    end else if (ref_hc == LINE_LAST) begin
      ref_hc <= '0;
      ref_vc <= (ref_vc == FRAME_LAST) ? 12'd0 : ref_vc + 12'd1;
    end else begin
      ref_hc <= ref_hc + 12'd1;
    end
  end

  // pointer taken in the last raster cycle
  always @(posedge pclk) begin
    if (reset) begin
      ref_rx  <= '0;
      ref_ry  <= '0;
      ref_alt <= 1'b0;
    end else if (ref_frame_end) begin
      ref_rx  <= clamp_to_limit(xpos, X_LIMIT);
      ref_ry  <= clamp_to_limit(ypos, Y_LIMIT);
      ref_alt <= mouse_left;
      if (xpos > X_LIMIT) clamp_x_samples <= clamp_x_samples + 1;
      if (ypos > Y_LIMIT) clamp_y_samples <= clamp_y_samples + 1;
    end
  end

  always_comb begin
    exp_blank_now   = (ref_hc >= H_VISIBLE) || (ref_vc >= V_VISIBLE);
    exp_in_rect_now = !exp_blank_now &&
                      (ref_hc >= ref_rx) && (ref_hc < ref_rx + BOX_W) &&
                      (ref_vc >= ref_ry) && (ref_vc < ref_ry + BOX_H);
    exp_hs_now      = (ref_hc >= HS_FIRST) && (ref_hc <= HS_LAST);
    exp_vs_now      = (ref_vc >= VS_FIRST) && (ref_vc <= VS_LAST);
    if (exp_blank_now) begin
      exp_rgb_now = 12'h000;
    end else if (exp_in_rect_now) begin
      exp_rgb_now = ref_alt ? 12'hf80 : 12'h44f;
    end else begin
      exp_rgb_now = border_colour(ref_hc, ref_vc);
    end
    // pins stay dark while reset is held
    if (reset) begin
      exp_hs_now      = 1'b0;
      exp_vs_now      = 1'b0;
      exp_blank_now   = 1'b1;
      exp_in_rect_now = 1'b0;
      exp_rgb_now     = 12'h000;
    end
  end

  // two pipeline stages in the DUT
  always @(posedge pclk) begin
    exp_hs_d1      <= exp_hs_now;
    exp_vs_d1      <= exp_vs_now;
    exp_blank_d1   <= exp_blank_now;
    exp_in_rect_d1 <= exp_in_rect_now;
    exp_rgb_d1     <= exp_rgb_now;
    exp_hs_q       <= exp_hs_d1;
    exp_vs_q       <= exp_vs_d1;
    exp_blank_q    <= exp_blank_d1;
    exp_in_rect_q  <= exp_in_rect_d1;
    exp_rgb_q      <= exp_rgb_d1;
  end

  // cycle count, timeout, fill coverage
  always @(posedge pclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (armed && exp_in_rect_q && exp_rgb_q == 12'h44f) fill_a_pixels <= fill_a_pixels + 1;
    if (armed && exp_in_rect_q && exp_rgb_q == 12'hf80) fill_b_pixels <= fill_b_pixels + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout: the run did not finish within four frames");
    end
  end

  `include "tb_checks.svh"

  // block until the reference raster starts the given line
  task automatic wait_line(input logic [11:0] line);
    do begin
      @(posedge pclk);
      #0.5;
    end while (!(ref_hc == 12'd0 && ref_vc == line));
  endtask

  task automatic move_pointer(input logic [11:0] x, input logic [11:0] y, input logic btn);
    xpos       = x;
    ypos       = y;
    mouse_left = btn;
  endtask

  initial begin
    int frame;
    void'($urandom(SEED));
    reset      = 1'b1;
    xpos       = '0;
    ypos       = '0;
    mouse_left = 1'b0;
    repeat (RESET_CYCLES) @(posedge pclk);
    #0.5;
    reset = 1'b0;
    for (frame = 0; frame < RUN_FRAMES; frame++) begin
      // moves here must not reach the screen this frame
      foreach (MOVE_LINES[i]) begin
        wait_line(MOVE_LINES[i]);
        move_pointer(12'($urandom % 1400), 12'($urandom % 1000), 1'($urandom));
      end
      // value held into the frame-end sample
      wait_line(SETUP_LINE);
      case (frame)
        0: move_pointer(12'(961 + $urandom % 3000), 12'($urandom % 721), 1'b1);
        1: move_pointer(12'($urandom % 961), 12'(721 + $urandom % 3000), 1'b0);
        default: move_pointer(12'(961 + $urandom % 3000), 12'(721 + $urandom % 3000), 1'b1);
      endcase
    end
    // first line of the next frame shows the last sample
    wait_line(12'd0);
    repeat (LINE_CYCLES + 4) @(posedge pclk);
    if (fill_a_pixels == 0 || fill_b_pixels == 0 ||
        clamp_x_samples == 0 || clamp_y_samples == 0) begin
      abort_run("stimulus did not reach both fills and both clamp edges");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* src.f */
+incdir+tests
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/frame_ctl.sv
rtl/draw_background.sv
rtl/draw_rect.sv
rtl/vga_top.sv
tests/tb_vga_top.sv

/* Makefile */
# Verilator build and run of the vga pipeline testbench
# any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_vga_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

.PHONY: sim clean

# build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
